// File: all.f
+incdir+tb
design/link_pkg.sv
design/link_regs.sv
design/frame_decoder.sv
design/tag_converter.sv
design/event_counter.sv
design/link_top.sv
tb/tb_link_top.sv

// File: design/event_counter.sv
// Event counter that counts rising edges per channel and keeps the latest timestamp
`timescale 1ns/1ns

module event_counter (
   input  logic                   sys_clk,
   input  logic                   sys_clk_rst,
   input  logic                   clear_i,
   // Timestamped lanes, always accepted
   input  link_pkg::time_beat_t   s_beat_i,
   input  logic                   s_valid_i,
   output link_pkg::count_array_t counts_o,
   output link_pkg::tagtime_t     last_time_o
);
   import link_pkg::*;

   // Rising edges of this beat per channel
   logic [NUM_COUNT_CHANNELS-1:0][HIT_WIDTH-1:0] lane_hits;
   lane_keep_t                                   lane_rise;
   logic                                         newest_valid;
   tagtime_t                                     newest_time;

   // Kept lanes that carry a rising edge
   assign lane_rise = s_beat_i.keep & s_beat_i.rising;

   // Sum hits per channel
   // Channels at or above NUM_COUNT_CHANNELS match no entry and are ignored
   always_comb begin
      lane_hits = '0;
      for (int ch = 0; ch < NUM_COUNT_CHANNELS; ch++) begin
         for (int lane = 0; lane < NUM_LANES; lane++) begin
            if (lane_rise[lane] && s_beat_i.channel[lane] == channel_t'(ch)) begin
               lane_hits[ch] = lane_hits[ch] + 1'b1;
            end
         end
      end
   end

   // Highest kept lane wins, any channel and either edge
   always_comb begin
      newest_valid = 1'b0;
      newest_time  = '0;
      for (int lane = 0; lane < NUM_LANES; lane++) begin
         if (s_beat_i.keep[lane]) begin
            newest_valid = 1'b1;
            newest_time  = s_beat_i.tagtime[lane];
         end
      end
   end

   // Counter bank
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         counts_o <= '0;
      end else if (clear_i) begin
         counts_o <= '0;
      end else if (s_valid_i) begin
         // Counters wrap at 32 bits
         for (int ch = 0; ch < NUM_COUNT_CHANNELS; ch++) begin
            counts_o[ch] <= counts_o[ch] + count_t'(lane_hits[ch]);
         end
      end
   end

   // Latest timestamp
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         last_time_o <= '0;
      end else if (clear_i) begin
         last_time_o <= '0;
      end else if (s_valid_i && newest_valid) begin
         // A beat with no kept lane leaves the old value
         last_time_o <= newest_time;
      end
   end

endmodule

// File: design/frame_decoder.sv
// Frame decoder that checks headers, drops bad frames and stamps tag beats with the wrap count
`timescale 1ns/1ns

module frame_decoder (
   input  logic                   sys_clk,
   input  logic                   sys_clk_rst,
   input  logic                   enable_i,
   input  logic                   clear_i,
   // Raw link stream
   input  link_pkg::link_beat_t   s_beat_i,
   input  logic                   s_valid_i,
   output logic                   s_ready_o,
   // Tag beats to the converter
   output link_pkg::tag_beat_t    m_beat_o,
   output logic                   m_valid_o,
   input  logic                   m_ready_i,
   output link_pkg::frame_stats_t stats_o
);
   import link_pkg::*;

   decode_state_t state;
   wrap_t         wrap_q;
   logic          accept;
   logic          magic_ok;
   tag_word_t     hdr_magic;
   wrap_t         hdr_wrap;

   // Stall while disabled or while the output register is blocked
   assign s_ready_o = enable_i & (~m_valid_o | m_ready_i);
   assign accept    = s_valid_i & s_ready_o;

   // Header fields, lane 0 carries the magic and lane 1 the wrap count
   assign hdr_magic = s_beat_i.data[0 +: LANE_WIDTH];
   assign hdr_wrap  = s_beat_i.data[LANE_WIDTH +: LANE_WIDTH];
   assign magic_ok  = (hdr_magic == FRAME_MAGIC);

   // Frame state and statistics
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         state   <= HEADER;
         stats_o <= '0;
      end else begin
         if (accept) begin
            case (state)
               HEADER: begin
                  // A one-beat frame has a header only and stays here
                  if (magic_ok) begin
                     stats_o.frames_ok <= stats_o.frames_ok + 1'b1;
                     if (!s_beat_i.last) begin
                        state <= TAGS;
                     end
                  end else begin
                     stats_o.frames_dropped <= stats_o.frames_dropped + 1'b1;
                     if (!s_beat_i.last) begin
                        state <= DISCARD;
                     end
                  end
               end
               TAGS, DISCARD: begin
                  if (s_beat_i.last) begin
                     state <= HEADER;
                  end
               end
               default: state <= HEADER;
            endcase
         end
         // Clear beats a same-cycle increment
         if (clear_i) begin
            stats_o <= '0;
         end
      end
   end

   // Wrap count of the current good frame
   always_ff @(posedge sys_clk) begin
      if (accept && state == HEADER && magic_ok) begin
         wrap_q <= hdr_wrap;
      end
   end

   // Output valid, set only by tag beats of a good frame
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         m_valid_o <= 1'b0;
      end else begin
         if (m_ready_i) begin
            m_valid_o <= 1'b0;
         end
         if (accept && state == TAGS) begin
            m_valid_o <= 1'b1;
         end
      end
   end

   // Output payload
   always_ff @(posedge sys_clk) begin
      if (accept && state == TAGS) begin
         m_beat_o.wrap <= wrap_q;
         m_beat_o.data <= s_beat_i.data;
         m_beat_o.keep <= s_beat_i.keep;
      end
   end

endmodule

// File: design/link_pkg.sv
// Link package holding the receive path constants, APB register map and shared types
package link_pkg;

   // Beat geometry, four tag words per 128-bit beat
   localparam int NUM_LANES  = 4;
   localparam int LANE_WIDTH = 32;
   localparam int BEAT_WIDTH = NUM_LANES * LANE_WIDTH;

   // Tag word layout
   localparam int SUBTICK_WIDTH = 26;
   localparam int CHANNEL_WIDTH = 5;
   localparam int RISING_BIT    = SUBTICK_WIDTH;

   // Timestamp units per raw tick
   localparam int TICK_SCALE = 3;

   // Counter bank sizing
   localparam int NUM_COUNT_CHANNELS = 8;
   localparam int COUNT_IDX_WIDTH    = $clog2(NUM_COUNT_CHANNELS);
   // Enough bits to count every lane of one beat on a single channel
   localparam int HIT_WIDTH          = $clog2(NUM_LANES + 1);

   // Plain vector types
   typedef logic [LANE_WIDTH-1:0]    tag_word_t;
   typedef logic [CHANNEL_WIDTH-1:0] channel_t;
   typedef logic [SUBTICK_WIDTH-1:0] subtick_t;
   typedef logic [31:0]              wrap_t;
   typedef logic [63:0]              tagtime_t;
   typedef logic [NUM_LANES-1:0]     lane_keep_t;
   typedef logic [31:0]              count_t;
   typedef logic [7:0]               apb_addr_t;
   typedef logic [31:0]              apb_data_t;

   // Expected lane 0 of a header beat
   localparam tag_word_t FRAME_MAGIC = 32'h5449_4D45;
   localparam apb_data_t LINK_ID     = 32'h7A61_0001;

   // Register byte offsets
   localparam apb_addr_t REG_ID             = 8'h00;
   localparam apb_addr_t REG_CTRL           = 8'h04;
   localparam apb_addr_t REG_FRAMES_OK      = 8'h08;
   localparam apb_addr_t REG_FRAMES_DROPPED = 8'h0C;
   localparam apb_addr_t REG_TIME_LO        = 8'h10;
   localparam apb_addr_t REG_TIME_HI        = 8'h14;
   localparam apb_addr_t REG_COUNT_BASE     = 8'h20;

   // CTRL bits
   localparam int CTRL_ENABLE_BIT = 0;
   localparam int CTRL_CLEAR_BIT  = 1;

   // Stream beats
   typedef struct packed {
      logic [BEAT_WIDTH-1:0] data;
      lane_keep_t            keep;
      logic                  last;
   } link_beat_t;

   typedef struct packed {
      wrap_t                 wrap;
      logic [BEAT_WIDTH-1:0] data;
      lane_keep_t            keep;
   } tag_beat_t;

   typedef struct packed {
      tagtime_t [NUM_LANES-1:0] tagtime;
      channel_t [NUM_LANES-1:0] channel;
      logic [NUM_LANES-1:0]     rising;
      lane_keep_t               keep;
   } time_beat_t;

   typedef count_t [NUM_COUNT_CHANNELS-1:0] count_array_t;

   // APB request and response
   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   typedef struct packed {
      count_t frames_ok;
      count_t frames_dropped;
   } frame_stats_t;

   typedef enum logic [1:0] {
      HEADER,
      TAGS,
      DISCARD
   } decode_state_t;

endpackage

// File: design/link_regs.sv
// APB register block with the enable and clear controls and status readback
`timescale 1ns/1ns

module link_regs (
   input  logic                   sys_clk,
   input  logic                   sys_clk_rst,
   input  link_pkg::apb_req_t     apb_req_i,
   output link_pkg::apb_rsp_t     apb_rsp_o,
   output logic                   enable_o,
   output logic                   clear_o,
   input  link_pkg::frame_stats_t stats_i,
   input  link_pkg::count_array_t counts_i,
   input  link_pkg::tagtime_t     last_time_i
);
   import link_pkg::*;

   logic                       access;
   logic                       write_ctrl;
   logic                       count_hit;
   apb_addr_t                  count_offs;
   logic [COUNT_IDX_WIDTH-1:0] count_idx;
   apb_data_t                  rdata;
   logic                       hit;

   // Access phase of an APB transfer
   assign access     = apb_req_i.psel & apb_req_i.penable;
   assign write_ctrl = access & apb_req_i.pwrite & (apb_req_i.paddr == REG_CTRL);

   // Counter window starts at REG_COUNT_BASE, one word per channel
   assign count_offs = apb_req_i.paddr - REG_COUNT_BASE;
   assign count_hit  = (apb_req_i.paddr >= REG_COUNT_BASE) &&
                       (count_offs < apb_addr_t'(4 * NUM_COUNT_CHANNELS)) &&
                       (apb_req_i.paddr[1:0] == 2'b00);
   assign count_idx  = count_offs[2 +: COUNT_IDX_WIDTH];

   // CTRL register
   // Writes land on the access-phase edge
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         enable_o <= 1'b0;
         clear_o  <= 1'b0;
      end else begin
         // Clear is a self-ending pulse, high for one cycle per write
         clear_o <= write_ctrl & apb_req_i.pwdata[CTRL_CLEAR_BIT];
         if (write_ctrl) begin
            enable_o <= apb_req_i.pwdata[CTRL_ENABLE_BIT];
         end
      end
   end

   // Readback multiplexer
   always_comb begin
      rdata = '0;
      hit   = 1'b1;
      case (apb_req_i.paddr)
         REG_ID:             rdata = LINK_ID;
         REG_CTRL:           rdata = apb_data_t'(enable_o);
         REG_FRAMES_OK:      rdata = stats_i.frames_ok;
         REG_FRAMES_DROPPED: rdata = stats_i.frames_dropped;
         REG_TIME_LO:        rdata = last_time_i[31:0];
         REG_TIME_HI:        rdata = last_time_i[63:32];
         default: begin
            if (count_hit) begin
               rdata = counts_i[count_idx];
            end else begin
               // Offset outside the map
               hit = 1'b0;
            end
         end
      endcase
   end

   // No wait states, error only on unmapped offsets
   always_comb begin
      apb_rsp_o.prdata  = rdata;
      apb_rsp_o.pready  = 1'b1;
      apb_rsp_o.pslverr = access & ~hit;
   end

endmodule

// File: design/link_top.sv
// Link receive top level joining register block, frame decoder, tag converter and counter
`timescale 1ns/1ns

module link_top (
   input  logic               sys_clk,
   input  logic               sys_clk_rst,
   // Incoming link stream
   input  link_pkg::link_beat_t s_beat_i,
   input  logic               s_valid_i,
   output logic               s_ready_o,
   // Register access
   input  link_pkg::apb_req_t apb_req_i,
   output link_pkg::apb_rsp_t apb_rsp_o
);
   import link_pkg::*;

   // Control from the register block
   logic         enable;
   logic         clear;

   // Status back to the register block
   frame_stats_t stats;
   count_array_t counts;
   tagtime_t     last_time;

   // Decoder to converter
   tag_beat_t    dec_beat;
   logic         dec_valid;
   logic         dec_ready;

   // Converter to counter
   time_beat_t   time_beat;
   logic         time_valid;

   link_regs link_regs_inst (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .apb_req_i   (apb_req_i),
      .apb_rsp_o   (apb_rsp_o),
      .enable_o    (enable),
      .clear_o     (clear),
      .stats_i     (stats),
      .counts_i    (counts),
      .last_time_i (last_time)
   );

   frame_decoder frame_decoder_inst (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .enable_i    (enable),
      .clear_i     (clear),
      .s_beat_i    (s_beat_i),
      .s_valid_i   (s_valid_i),
      .s_ready_o   (s_ready_o),
      .m_beat_o    (dec_beat),
      .m_valid_o   (dec_valid),
      .m_ready_i   (dec_ready),
      .stats_o     (stats)
   );

   // Counter never stalls, so the converter output is always taken
   tag_converter tag_converter_inst (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .s_beat_i    (dec_beat),
      .s_valid_i   (dec_valid),
      .s_ready_o   (dec_ready),
      .m_beat_o    (time_beat),
      .m_valid_o   (time_valid),
      .m_ready_i   (1'b1)
   );

   event_counter event_counter_inst (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .clear_i     (clear),
      .s_beat_i    (time_beat),
      .s_valid_i   (time_valid),
      .counts_o    (counts),
      .last_time_o (last_time)
   );

endmodule

// File: design/tag_converter.sv
// Tag converter that turns tag words and the wrap count into scaled 64-bit timestamps
`timescale 1ns/1ns

module tag_converter (
   input  logic                 sys_clk,
   input  logic                 sys_clk_rst,
   // Tag beats from the decoder
   input  link_pkg::tag_beat_t  s_beat_i,
   input  logic                 s_valid_i,
   output logic                 s_ready_o,
   // Timestamped lanes to the counter
   output link_pkg::time_beat_t m_beat_o,
   output logic                 m_valid_o,
   input  logic                 m_ready_i
);
   import link_pkg::*;

   time_beat_t next_beat;
   logic       accept;

   assign s_ready_o = ~m_valid_o | m_ready_i;
   assign accept    = s_valid_i & s_ready_o;

   // Per-lane split and timestamp
   always_comb begin
      tag_word_t word;
      subtick_t  subtick;
      tagtime_t  ticks;
      next_beat      = '0;
      next_beat.keep = s_beat_i.keep;
      for (int lane = 0; lane < NUM_LANES; lane++) begin
         word    = s_beat_i.data[lane*LANE_WIDTH +: LANE_WIDTH];
         subtick = word[SUBTICK_WIDTH-1:0];
         // Wrap count sits above the subtick field, so concatenation is the shift and add
         ticks   = tagtime_t'({s_beat_i.wrap, subtick});
         next_beat.channel[lane] = word[LANE_WIDTH-1 -: CHANNEL_WIDTH];
         next_beat.rising[lane]  = word[RISING_BIT];
         next_beat.tagtime[lane] = ticks * tagtime_t'(TICK_SCALE);
      end
   end

   // Output valid
   always_ff @(posedge sys_clk) begin
      if (sys_clk_rst) begin
         m_valid_o <= 1'b0;
      end else if (s_ready_o) begin
         m_valid_o <= s_valid_i;
      end
   end

   // Output payload, keep travels with the timestamps
   always_ff @(posedge sys_clk) begin
      if (accept) begin
         m_beat_o <= next_beat;
      end
   end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the link receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_link_top -f all.f -o tb_link_top

# A $fatal in the testbench gives a failing exit status
./obj_dir/tb_link_top

// File: tb/tb_link_table.svh
// Frame table, random tag source and value check for the link receive testbench
`ifndef TB_LINK_TABLE_SVH
`define TB_LINK_TABLE_SVH

// One frame per row
// Expected statistics are running totals after the row
typedef struct packed {
   logic [8*12-1:0] name;
   logic            good;
   wrap_t           wrap;
   logic [7:0]      beats;
   lane_keep_t      keep;
   count_t          exp_ok;
   count_t          exp_dropped;
} frame_row_t;

localparam int NUM_ROWS = 8;

localparam frame_row_t ROWS [NUM_ROWS] = '{
   '{"good_full",    1'b1, 32'h0000_0001, 8'd3, 4'b1111, 32'd1, 32'd0},
   '{"good_wrapbig", 1'b1, 32'h8F3C_21A5, 8'd4, 4'b1111, 32'd2, 32'd0},
   '{"bad_magic",    1'b0, 32'h0000_0010, 8'd2, 4'b1111, 32'd2, 32'd1},
   '{"good_half",    1'b1, 32'h0000_4321, 8'd2, 4'b0011, 32'd3, 32'd1},
   '{"good_sparse",  1'b1, 32'hFFFF_FFFF, 8'd3, 4'b0101, 32'd4, 32'd1},
   '{"bad_short",    1'b0, 32'h0000_0000, 8'd1, 4'b1111, 32'd4, 32'd2},
   '{"good_long",    1'b1, 32'h1234_5678, 8'd6, 4'b1111, 32'd5, 32'd2},
   '{"bad_long",     1'b0, 32'h00AB_CDEF, 8'd5, 4'b1001, 32'd5, 32'd3}
};

// LCG state for the tag words
logic [31:0] lcg_state = 32'ha7809a78;

function automatic logic [31:0] next_random();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// Compare one value against its expected value
task automatic check_value(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
   if (actual !== expected) begin
      $display("FAILED %s: expected %0h, actual %0h", what, expected, actual);
      stop_run("A checked value did not match its expected value");
   end
endtask

`endif

// File: tb/tb_link_top.sv
// Testbench for the link receive path, sending frames and checking results over APB
`timescale 1ns/1ns

module tb_link_top;
   import link_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DELAY  = 1;
   localparam int SAMPLE_DELAY = 40;
   // Acceptance of a tag beat to readable counters
   localparam int PIPE_CYCLES  = 3;
   // One full register sweep, with margin
   localparam int SWEEP_CYCLES = 40;

   logic       sys_clk;
   logic       sys_clk_rst;
   link_beat_t s_beat;
   logic       s_valid;
   logic       s_ready;
   apb_req_t   apb_req;
   apb_rsp_t   apb_rsp;

   // Reference model state
   count_t     exp_counts [NUM_COUNT_CHANNELS];
   tagtime_t   exp_time;

   task automatic stop_run(input string reason);
      $display("Some tests failed");
      $fatal(1, "%s", reason);
   endtask

   `include "tb_link_table.svh"

   link_top link_top_inst (
      .sys_clk     (sys_clk),
      .sys_clk_rst (sys_clk_rst),
      .s_beat_i    (s_beat),
      .s_valid_i   (s_valid),
      .s_ready_o   (s_ready),
      .apb_req_i   (apb_req),
      .apb_rsp_o   (apb_rsp)
   );

   always #(CLK_PERIOD/2) sys_clk = ~sys_clk;

   // APB write, setup then access phase
   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      apb_req        = '0;
      apb_req.psel   = 1'b1;
      apb_req.pwrite = 1'b1;
      apb_req.paddr  = addr;
      apb_req.pwdata = data;
      @(posedge sys_clk);
      #DRIVE_DELAY;
      apb_req.penable = 1'b1;
      @(posedge sys_clk);
      #DRIVE_DELAY;
      apb_req = '0;
   endtask

   // APB read, sampled mid access phase
   task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err,
                           output logic ready);
      apb_req       = '0;
      apb_req.psel  = 1'b1;
      apb_req.paddr = addr;
      @(posedge sys_clk);
      #DRIVE_DELAY;
      apb_req.penable = 1'b1;
      #SAMPLE_DELAY;
      data  = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      ready = apb_rsp.pready;
      @(posedge sys_clk);
      #DRIVE_DELAY;
      apb_req = '0;
   endtask

   task automatic read_check(input apb_addr_t addr, input string what, input apb_data_t expected);
      apb_data_t rdata;
      logic      rerr;
      logic      rrdy;
      apb_read(addr, rdata, rerr, rrdy);
      check_value(what, 64'(expected), 64'(rdata));
      check_value({what, " pslverr"}, 64'd0, 64'(rerr));
      check_value({what, " pready"}, 64'd1, 64'(rrdy));
   endtask

   // Hold one beat until the DUT takes it
   task automatic send_beat(input link_beat_t beat);
      logic taken;
      s_beat  = beat;
      s_valid = 1'b1;
      taken   = 1'b0;
      while (!taken) begin
         #SAMPLE_DELAY;
         taken = s_ready;
         @(posedge sys_clk);
         #DRIVE_DELAY;
      end
      s_valid = 1'b0;
   endtask

   // Counts rising kept lanes and tracks the highest kept lane's time
   task automatic model_beat(input wrap_t wrap, input link_beat_t beat);
      tag_word_t word;
      int        ch;
      tagtime_t  ticks;
      for (int lane = 0; lane < NUM_LANES; lane++) begin
         if (beat.keep[lane]) begin
            word  = beat.data[lane*LANE_WIDTH +: LANE_WIDTH];
            ch    = int'(word[31:27]);
            if (word[26] && ch < NUM_COUNT_CHANNELS) begin
               exp_counts[ch] = exp_counts[ch] + 32'd1;
            end
            ticks    = (tagtime_t'(wrap) << SUBTICK_WIDTH) + tagtime_t'(word[25:0]);
            exp_time = ticks * tagtime_t'(TICK_SCALE);
         end
      end
   endtask

   task automatic send_frame(input frame_row_t row);
      link_beat_t beat;
      tag_word_t  word;
      beat = '0;
      beat.data[0 +: LANE_WIDTH]          = row.good ? FRAME_MAGIC : ~FRAME_MAGIC;
      beat.data[LANE_WIDTH +: LANE_WIDTH] = row.wrap;
      beat.keep = '1;
      beat.last = (row.beats == 8'd0);
      send_beat(beat);
      for (int b = 0; b < int'(row.beats); b++) begin
         for (int lane = 0; lane < NUM_LANES; lane++) begin
            word = next_random();
            // Top channel bit cleared, so half the tags land on counted channels
            word[31] = 1'b0;
            // First tag beat stacks every lane on one counted channel as a rising edge
            if (b == 0) begin
               word[31:26] = {2'b00, row.wrap[2:0], 1'b1};
            end
            beat.data[lane*LANE_WIDTH +: LANE_WIDTH] = word;
         end
         beat.keep = row.keep;
         beat.last = (b == int'(row.beats) - 1);
         if (row.good) begin
            model_beat(row.wrap, beat);
         end
         send_beat(beat);
      end
   endtask

   task automatic clear_model();
      for (int ch = 0; ch < NUM_COUNT_CHANNELS; ch++) begin
         exp_counts[ch] = '0;
      end
      exp_time = '0;
   endtask

   // Full sweep of counters, statistics and latest time
   task automatic check_state(input string name, input count_t exp_ok, input count_t exp_dropped);
      for (int ch = 0; ch < NUM_COUNT_CHANNELS; ch++) begin
         read_check(REG_COUNT_BASE + apb_addr_t'(4 * ch), $sformatf("%s count%0d", name, ch),
                    exp_counts[ch]);
      end
      read_check(REG_FRAMES_OK, {name, " frames_ok"}, exp_ok);
      read_check(REG_FRAMES_DROPPED, {name, " frames_dropped"}, exp_dropped);
      read_check(REG_TIME_LO, {name, " time_lo"}, exp_time[31:0]);
      read_check(REG_TIME_HI, {name, " time_hi"}, exp_time[63:32]);
   endtask

   initial begin
      apb_data_t rdata;
      logic      rerr;
      logic      rrdy;
      sys_clk     = 1'b0;
      sys_clk_rst = 1'b1;
      s_beat      = '0;
      s_valid     = 1'b0;
      apb_req     = '0;
      clear_model();
      repeat (3) @(posedge sys_clk);
      #DRIVE_DELAY;
      sys_clk_rst = 1'b0;

      // Identity word and an unmapped offset
      read_check(REG_ID, "id", LINK_ID);
      apb_read(8'h18, rdata, rerr, rrdy);
      check_value("unmapped pslverr", 64'd1, 64'(rerr));
      check_value("unmapped pready", 64'd1, 64'(rrdy));

      // Stream stalls until enable is written
      repeat (3) begin
         #SAMPLE_DELAY;
         check_value("ready before enable", 64'd0, 64'(s_ready));
         @(posedge sys_clk);
         #DRIVE_DELAY;
      end
      check_state("after reset", 32'd0, 32'd0);
      apb_write(REG_CTRL, 32'h1);
      #SAMPLE_DELAY;
      check_value("ready after enable", 64'd1, 64'(s_ready));
      @(posedge sys_clk);
      #DRIVE_DELAY;

      for (int i = 0; i < NUM_ROWS; i++) begin
         send_frame(ROWS[i]);
         repeat (PIPE_CYCLES) @(posedge sys_clk);
         #DRIVE_DELAY;
         check_state($sformatf("%s", ROWS[i].name), ROWS[i].exp_ok, ROWS[i].exp_dropped);
      end

      // Clear keeps enable and zeroes everything else
      apb_write(REG_CTRL, 32'h3);
      clear_model();
      check_state("after clear", 32'd0, 32'd0);
      read_check(REG_CTRL, "ctrl after clear", 32'h1);

      $display("All tests passed");
      $finish;
   end

   // Limit scales with the beats in the table and one sweep per row
   initial begin
      int     total_beats;
      longint limit;
      total_beats = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         total_beats = total_beats + 1 + int'(ROWS[i].beats);
      end
      limit = longint'(total_beats + (NUM_ROWS + 4) * SWEEP_CYCLES) * CLK_PERIOD * 2;
      #(limit);
      stop_run("Watchdog timeout, the run did not finish in time");
   end

endmodule
